/* bench/id_stage_properties.sv */
module id_stage_properties (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        load_use_i,
    input logic        hazard_i,
    input logic        rf_we_o,
    input logic        mem_rd_o,
    input logic        mem_wr_o,
    input logic        is_branch_jal_o,
    input logic [31:0] alu_src_a_o,
    input logic [31:0] alu_src_b_o,
    input logic [31:0] br_src_a_o,
    input logic [31:0] store_data_o,
    input logic [4:0]  rf_waddr_o
);

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !rf_we_o && !mem_rd_o && !mem_wr_o && !is_branch_jal_o)
        else $error("control outputs active after reset");

    a_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_use_i |=> !rf_we_o && !mem_rd_o && !mem_wr_o)
        else $error("load-use cycle not followed by a bubble");

    // Back-pressure freezes the whole ID/EX register
    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hazard_i && !load_use_i |=> $stable(alu_src_a_o) && $stable(alu_src_b_o)
            && $stable(br_src_a_o) && $stable(store_data_o) && $stable(rf_waddr_o)
            && $stable(rf_we_o))
        else $error("ID/EX outputs changed during a stall");

endmodule

bind operand_select id_stage_properties u_id_stage_properties (.*);

/* bench/id_stage_tb.sv */
module id_stage_tb;

    typedef struct packed {
        logic [3:0]  alu_op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bra;
        logic [31:0] brb;
        logic        we;
        logic [4:0]  wa;
        logic        mrd;
        logic        mwr;
        logic [1:0]  size;
        logic        sext;
        logic [31:0] sd;
        logic        bj;
    } idex_t;

    localparam int n_rand = 400;
    localparam int limit  = 2 * (20 + n_rand) + 50;

    logic        clk_i, rst_n_i, ex_we_i, mem_we_i, hazard_i, hazard_o;
    logic [31:0] instr_i, pc_i, rf_data_a_i, rf_data_b_i, ex_data_i, mem_data_i;
    logic [4:0]  rf_raddr_a_o, rf_raddr_b_o, ex_waddr_i, mem_waddr_i, rf_waddr_o;
    logic [31:0] alu_src_a_o, alu_src_b_o, br_src_a_o, br_src_b_o, store_data_o;
    logic        rf_we_o, mem_rd_o, mem_wr_o, mem_sign_ext_o, is_branch_jal_o;
    rv_id_pkg::alu_op_e   alu_op_o;
    rv_id_pkg::mem_size_e mem_size_o;

    integer seed = 64;
    int     cycles = 0;
    int     err_count = 0;
    logic   hold_req = 1'b0;
    logic [31:0] pc_next = 32'h0000_1000;
    string  test_name = "reset";
    idex_t  exp_state = '0;

    id_stage_top u_id_stage_top (.*);

    // Register file model, value depends on every address bit
    function automatic logic [31:0] rf_value(input logic [4:0] a);
        return (a == 0) ? 32'h0 : {a, 3'b101, a, 3'b010, a, 3'b110, a, 1'b1};
    endfunction

    assign rf_data_a_i = rf_value(rf_raddr_a_o);
    assign rf_data_b_i = rf_value(rf_raddr_b_o);

    function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? rv_id_pkg::ALU_SUB : rv_id_pkg::ALU_ADD;
            3'd1:    return rv_id_pkg::ALU_SLL;
            3'd2:    return rv_id_pkg::ALU_SLT;
            3'd3:    return rv_id_pkg::ALU_SLTU;
            3'd4:    return rv_id_pkg::ALU_XOR;
            3'd5:    return alt ? rv_id_pkg::ALU_SRA : rv_id_pkg::ALU_SRL;
            3'd6:    return rv_id_pkg::ALU_OR;
            default: return rv_id_pkg::ALU_AND;
        endcase
    endfunction

    function automatic logic [31:0] operand_value(input logic used, input logic [4:0] r,
                                                  input logic exw, input logic [4:0] exa,
                                                  input logic [31:0] exd, input logic mw,
                                                  input logic [4:0] ma,
                                                  input logic [31:0] md);
        if (used && r != 0 && exw && exa == r)
            return exd;
        if (used && r != 0 && mw && ma == r)
            return md;
        return rf_value(r);
    endfunction

    function automatic void ref_decode(
        input logic [31:0] instr, input logic [31:0] pc, input logic exw,
        input logic [4:0] exa, input logic [31:0] exd, input logic mw,
        input logic [4:0] ma, input logic [31:0] md, input logic hz, input logic rst_n,
        input idex_t prev, output idex_t nxt, output logic haz,
        output logic [4:0] ra, output logic [4:0] rb);
        logic [31:0] w, imm, fa, fb;
        logic [1:0]  sa;
        logic        sb, u1, u2, jump, known;
        idex_t       cur;
        w = instr;
        known = w[6:0] inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
                               7'h13, 7'h33};
        if (!known)
            w = rv_id_pkg::nop_instr;
        ra = w[19:15];
        rb = w[24:20];
        cur = '0;
        cur.wa = w[11:7];
        cur.size = rv_id_pkg::MEM_WORD;
        cur.alu_op = rv_id_pkg::ALU_ADD;
        imm = {{20{w[31]}}, w[31:20]};
        {sa, sb, u1, u2, jump} = {2'd0, 1'b1, 1'b0, 1'b0, 1'b0};
        case (w[6:0])
            7'h37: {cur.we, imm, sa, cur.alu_op} = {1'b1, w[31:12], 12'b0, 2'd2, 4'd10};
            7'h17: {cur.we, imm, sa} = {1'b1, w[31:12], 12'b0, 2'd1};
            7'h6f: begin
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                {cur.we, sa, cur.bj, jump} = {1'b1, 2'd1, 1'b1, 1'b1};
            end
            7'h67: {cur.we, u1, cur.bj, jump} = 4'b1111;
            7'h63: begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                {u1, u2, sa, cur.bj} = {1'b1, 1'b1, 2'd1, 1'b1};
            end
            7'h03: {cur.we, u1, cur.mrd, cur.size, cur.sext} = {3'b111, w[13:12], ~w[14]};
            7'h23: begin
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
                {u1, u2, cur.mwr, cur.size} = {3'b111, w[13:12]};
            end
            7'h13: begin
                {cur.we, u1} = 2'b11;
                cur.alu_op = alu_of(w[14:12], w[14:12] == 3'd5 && w[30]);
            end
            default: begin
                {cur.we, u1, u2, sb} = 4'b1110;
                cur.alu_op = alu_of(w[14:12], w[30]);
            end
        endcase
        // Unsupported opcodes write nothing
        if (!known)
            cur.we = 1'b0;
        fa = operand_value(u1, ra, exw, exa, exd, mw, ma, md);
        fb = operand_value(u2, rb, exw, exa, exd, mw, ma, md);
        cur.a = (sa == 0) ? fa : (sa == 1) ? pc : 32'h0;
        cur.b = sb ? imm : fb;
        cur.bra = jump ? pc + 32'd4 : fa;
        cur.brb = fb;
        cur.sd = fb;
        haz = prev.mrd && prev.wa != 0 && ((u1 && ra == prev.wa) || (u2 && rb == prev.wa));
        nxt = prev;
        if (!rst_n) begin
            nxt = '0;
        end else if (haz) begin
            nxt = '0;
            nxt.size = rv_id_pkg::MEM_WORD;
        end else if (!hz) begin
            nxt = cur;
        end
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            err_count++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Compare on the falling edge, half a cycle away from any input change
    always @(negedge clk_i) begin
        idex_t       nxt;
        logic        haz;
        logic [4:0]  ra, rb;
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1);
        end
        ref_decode(instr_i, pc_i, ex_we_i, ex_waddr_i, ex_data_i, mem_we_i, mem_waddr_i,
                   mem_data_i, hazard_i, rst_n_i, exp_state, nxt, haz, ra, rb);
        check_val("rf_raddr_a", ra, rf_raddr_a_o);
        check_val("rf_raddr_b", rb, rf_raddr_b_o);
        check_val("hazard_o", haz, hazard_o);
        check_val("alu_op", exp_state.alu_op, alu_op_o);
        check_val("alu_src_a", exp_state.a, alu_src_a_o);
        check_val("alu_src_b", exp_state.b, alu_src_b_o);
        check_val("br_src_a", exp_state.bra, br_src_a_o);
        check_val("br_src_b", exp_state.brb, br_src_b_o);
        check_val("rf_we", exp_state.we, rf_we_o);
        check_val("rf_waddr", exp_state.wa, rf_waddr_o);
        check_val("mem_rd", exp_state.mrd, mem_rd_o);
        check_val("mem_wr", exp_state.mwr, mem_wr_o);
        check_val("mem_size", exp_state.size, mem_size_o);
        check_val("mem_sign_ext", exp_state.sext, mem_sign_ext_o);
        check_val("store_data", exp_state.sd, store_data_o);
        check_val("is_branch_jal", exp_state.bj, is_branch_jal_o);
        hold_req = haz;
        exp_state = nxt;
    end

    // The source keeps the instruction while hazard_o is up
    task automatic drive(input logic [31:0] instr, input logic exw, input logic [4:0] exa,
                         input logic mw, input logic [4:0] ma, input logic hz);
        @(posedge clk_i);
        while (hold_req)
            @(posedge clk_i);
        instr_i <= instr;
        pc_i <= pc_next;
        pc_next = pc_next + 32'd4;
        ex_we_i <= exw;
        ex_waddr_i <= exa;
        ex_data_i <= $random(seed);
        mem_we_i <= mw;
        mem_waddr_i <= ma;
        mem_data_i <= $random(seed);
        hazard_i <= hz;
    endtask

    initial begin
        logic [6:0]  ops [10];
        logic [31:0] w;
        ops = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33, 7'h7f};
        {rst_n_i, ex_we_i, mem_we_i, hazard_i} = 4'b0;
        {instr_i, pc_i, ex_data_i, mem_data_i} = '0;
        {ex_waddr_i, mem_waddr_i} = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        test_name = "opcodes";
        drive(32'h123452B7, 0, 0, 0, 0, 0);
        drive(32'h00001317, 0, 0, 0, 0, 0);
        drive(32'h008000EF, 0, 0, 0, 0, 0);
        drive(32'h004100E7, 0, 0, 0, 0, 0);
        drive(32'h00208463, 0, 0, 0, 0, 0);
        drive(32'h0071A423, 0, 0, 0, 0, 0);
        drive(32'h40345493, 0, 0, 0, 0, 0);
        drive(32'hFFFFFFFF, 0, 0, 0, 0, 0);
        test_name = "bypass";
        drive(32'h40940533, 1, 8, 1, 8, 0);
        drive(32'h40940533, 0, 8, 1, 9, 0);
        drive(32'h00000533, 1, 0, 1, 0, 0);
        // LUI fields rs1 = x8 and rs2 = x3 are unused and must not forward
        drive(32'h123452B7, 1, 8, 1, 3, 0);
        test_name = "load_use";
        drive(32'hFFC1A383, 0, 0, 0, 0, 0);
        drive(32'h00138413, 1, 7, 0, 0, 0);
        drive(32'h40940533, 0, 0, 0, 0, 0);
        test_name = "stall";
        drive(32'h00138413, 0, 0, 0, 0, 1);
        drive(32'h40940533, 0, 0, 0, 0, 1);
        drive(32'h40940533, 0, 0, 0, 0, 0);
        test_name = "random";
        repeat (n_rand) begin
            w = $random(seed);
            w[6:0] = ops[($random(seed) & 32'h7fff) % 10];
            w[11:9] = 3'b0;
            w[19:17] = 3'b0;
            w[24:22] = 3'b0;
            drive(w, $random(seed), $random(seed) & 3, $random(seed), $random(seed) & 3,
                  ($random(seed) & 7) == 0);
        end
        repeat (3) @(posedge clk_i);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* hw/bypass_controller.sv */
module bypass_controller (
    decode_if.bypass                             dec,
    input  logic                                 ex_we_i,
    input  logic [rv_id_pkg::reg_addr_width-1:0] ex_waddr_i,
    input  logic                                 mem_we_i,
    input  logic [rv_id_pkg::reg_addr_width-1:0] mem_waddr_i,
    input  logic [rv_id_pkg::reg_addr_width-1:0] idex_rd_i,
    input  logic                                 idex_load_i,
    output rv_id_pkg::bypass_sel_e               byp_a_o,
    output rv_id_pkg::bypass_sel_e               byp_b_o,
    output logic                                 load_use_o
);

    logic hit_a;
    logic hit_b;

    // EX is younger than MEM, so it has priority
    function automatic rv_id_pkg::bypass_sel_e pick_source(
        input logic                                 used,
        input logic [rv_id_pkg::reg_addr_width-1:0] src,
        input logic                                 ex_we,
        input logic [rv_id_pkg::reg_addr_width-1:0] ex_waddr,
        input logic                                 mem_we,
        input logic [rv_id_pkg::reg_addr_width-1:0] mem_waddr
    );
        if (!used || src == '0) begin
            return rv_id_pkg::BY_RF;
        end
        if (ex_we && ex_waddr == src) begin
            return rv_id_pkg::BY_EX;
        end
        if (mem_we && mem_waddr == src) begin
            return rv_id_pkg::BY_MEM;
        end
        return rv_id_pkg::BY_RF;
    endfunction

    always_comb begin
        byp_a_o = pick_source(dec.rs1_used, dec.rs1, ex_we_i, ex_waddr_i,
                              mem_we_i, mem_waddr_i);
        byp_b_o = pick_source(dec.rs2_used, dec.rs2, ex_we_i, ex_waddr_i,
                              mem_we_i, mem_waddr_i);
    end

    assign hit_a = dec.rs1_used && dec.rs1 == idex_rd_i;
    assign hit_b = dec.rs2_used && dec.rs2 == idex_rd_i;

    // Load data is not ready until MEM, one stage too late
    assign load_use_o = idex_load_i && idex_rd_i != '0 && (hit_a || hit_b);

endmodule

/* hw/decode_if.sv */
interface decode_if;

    rv_id_pkg::opcode_e                    opcode;
    logic [rv_id_pkg::reg_addr_width-1:0]  rs1;
    logic [rv_id_pkg::reg_addr_width-1:0]  rs2;
    logic                                  rs1_used;
    logic                                  rs2_used;
    logic [rv_id_pkg::reg_addr_width-1:0]  rd;
    logic                                  rf_we;
    logic [rv_id_pkg::word_width-1:0]      imm;
    rv_id_pkg::alu_op_e                    alu_op;
    rv_id_pkg::src_a_sel_e                 src_a_sel;
    rv_id_pkg::src_b_sel_e                 src_b_sel;
    logic                                  mem_rd;
    logic                                  mem_wr;
    rv_id_pkg::mem_size_e                  mem_size;
    logic                                  mem_sign_ext;
    logic                                  is_branch_jal;

    modport decoder (
        output opcode, rs1, rs2, rs1_used, rs2_used, rd, rf_we, imm, alu_op,
               src_a_sel, src_b_sel, mem_rd, mem_wr, mem_size, mem_sign_ext,
               is_branch_jal
    );

    modport bypass (input rs1, rs2, rs1_used, rs2_used);

    modport operand (
        input opcode, rs1, rs2, rs1_used, rs2_used, rd, rf_we, imm, alu_op,
              src_a_sel, src_b_sel, mem_rd, mem_wr, mem_size, mem_sign_ext,
              is_branch_jal
    );

endinterface

/* hw/id_stage_top.sv */
module id_stage_top (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic [rv_id_pkg::word_width-1:0]     instr_i,
    input  logic [rv_id_pkg::word_width-1:0]     pc_i,
    output logic [rv_id_pkg::reg_addr_width-1:0] rf_raddr_a_o,
    output logic [rv_id_pkg::reg_addr_width-1:0] rf_raddr_b_o,
    input  logic [rv_id_pkg::word_width-1:0]     rf_data_a_i,
    input  logic [rv_id_pkg::word_width-1:0]     rf_data_b_i,
    input  logic                                 ex_we_i,
    input  logic [rv_id_pkg::reg_addr_width-1:0] ex_waddr_i,
    input  logic [rv_id_pkg::word_width-1:0]     ex_data_i,
    input  logic                                 mem_we_i,
    input  logic [rv_id_pkg::reg_addr_width-1:0] mem_waddr_i,
    input  logic [rv_id_pkg::word_width-1:0]     mem_data_i,
    input  logic                                 hazard_i,
    output logic                                 hazard_o,
    output rv_id_pkg::alu_op_e                   alu_op_o,
    output logic [rv_id_pkg::word_width-1:0]     alu_src_a_o,
    output logic [rv_id_pkg::word_width-1:0]     alu_src_b_o,
    output logic [rv_id_pkg::word_width-1:0]     br_src_a_o,
    output logic [rv_id_pkg::word_width-1:0]     br_src_b_o,
    output logic                                 rf_we_o,
    output logic [rv_id_pkg::reg_addr_width-1:0] rf_waddr_o,
    output logic                                 mem_rd_o,
    output logic                                 mem_wr_o,
    output rv_id_pkg::mem_size_e                 mem_size_o,
    output logic                                 mem_sign_ext_o,
    output logic [rv_id_pkg::word_width-1:0]     store_data_o,
    output logic                                 is_branch_jal_o
);

    rv_id_pkg::bypass_sel_e               byp_a;
    rv_id_pkg::bypass_sel_e               byp_b;
    logic                                 load_use;
    logic [rv_id_pkg::reg_addr_width-1:0] idex_rd;
    logic                                 idex_load;

    decode_if dec_bus ();

    assign rf_raddr_a_o = dec_bus.rs1;
    assign rf_raddr_b_o = dec_bus.rs2;
    assign hazard_o     = load_use;

    instr_decoder u_instr_decoder (
        .instr_i (instr_i),
        .dec     (dec_bus.decoder)
    );

    bypass_controller u_bypass_controller (
        .dec         (dec_bus.bypass),
        .ex_we_i     (ex_we_i),
        .ex_waddr_i  (ex_waddr_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .idex_rd_i   (idex_rd),
        .idex_load_i (idex_load),
        .byp_a_o     (byp_a),
        .byp_b_o     (byp_b),
        .load_use_o  (load_use)
    );

    operand_select u_operand_select (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .dec             (dec_bus.operand),
        .pc_i            (pc_i),
        .rf_data_a_i     (rf_data_a_i),
        .rf_data_b_i     (rf_data_b_i),
        .ex_data_i       (ex_data_i),
        .mem_data_i      (mem_data_i),
        .byp_a_i         (byp_a),
        .byp_b_i         (byp_b),
        .load_use_i      (load_use),
        .hazard_i        (hazard_i),
        .idex_rd_o       (idex_rd),
        .idex_load_o     (idex_load),
        .alu_op_o        (alu_op_o),
        .alu_src_a_o     (alu_src_a_o),
        .alu_src_b_o     (alu_src_b_o),
        .br_src_a_o      (br_src_a_o),
        .br_src_b_o      (br_src_b_o),
        .rf_we_o         (rf_we_o),
        .rf_waddr_o      (rf_waddr_o),
        .mem_rd_o        (mem_rd_o),
        .mem_wr_o        (mem_wr_o),
        .mem_size_o      (mem_size_o),
        .mem_sign_ext_o  (mem_sign_ext_o),
        .store_data_o    (store_data_o),
        .is_branch_jal_o (is_branch_jal_o)
    );

endmodule

/* hw/instr_decoder.sv */
module instr_decoder (
    input rv_id_pkg::instr_u instr_i,
    decode_if.decoder        dec
);

    rv_id_pkg::opcode_e               op;
    rv_id_pkg::instr_u                ins;
    logic [rv_id_pkg::word_width-1:0] imm_i;
    logic [rv_id_pkg::word_width-1:0] imm_s;
    logic [rv_id_pkg::word_width-1:0] imm_b;
    logic [rv_id_pkg::word_width-1:0] imm_u;
    logic [rv_id_pkg::word_width-1:0] imm_j;

    function automatic rv_id_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                          input logic       alt);
        case (f3)
            3'b000:  return alt ? rv_id_pkg::ALU_SUB : rv_id_pkg::ALU_ADD;
            3'b001:  return rv_id_pkg::ALU_SLL;
            3'b010:  return rv_id_pkg::ALU_SLT;
            3'b011:  return rv_id_pkg::ALU_SLTU;
            3'b100:  return rv_id_pkg::ALU_XOR;
            3'b101:  return alt ? rv_id_pkg::ALU_SRA : rv_id_pkg::ALU_SRL;
            3'b110:  return rv_id_pkg::ALU_OR;
            default: return rv_id_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        case (instr_i.r.opcode)
            rv_id_pkg::OPCODE_LUI, rv_id_pkg::OPCODE_AUIPC, rv_id_pkg::OPCODE_JAL,
            rv_id_pkg::OPCODE_JALR, rv_id_pkg::OPCODE_BRANCH, rv_id_pkg::OPCODE_LOAD,
            rv_id_pkg::OPCODE_STORE, rv_id_pkg::OPCODE_OP_IMM, rv_id_pkg::OPCODE_OP:
                op = rv_id_pkg::opcode_e'(instr_i.r.opcode);
            default:
                op = rv_id_pkg::OPCODE_NONE;
        endcase
    end

    // Unsupported words are decoded from the NOP instead
    assign ins = (op == rv_id_pkg::OPCODE_NONE) ? rv_id_pkg::nop_instr : instr_i;

    assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    assign imm_b = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                    ins.b.imm4_1, 1'b0};
    assign imm_u = {ins.u.imm, 12'b0};
    assign imm_j = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                    ins.j.imm10_1, 1'b0};

    always_comb begin
        dec.opcode        = op;
        dec.rs1           = ins.r.rs1;
        dec.rs2           = ins.r.rs2;
        dec.rd            = ins.r.rd;
        dec.rs1_used      = 1'b0;
        dec.rs2_used      = 1'b0;
        dec.rf_we         = 1'b0;
        dec.imm           = imm_i;
        dec.alu_op        = rv_id_pkg::ALU_ADD;
        dec.src_a_sel     = rv_id_pkg::SRC_A_REG;
        dec.src_b_sel     = rv_id_pkg::SRC_B_IMM;
        dec.mem_rd        = 1'b0;
        dec.mem_wr        = 1'b0;
        dec.mem_size      = rv_id_pkg::MEM_WORD;
        dec.mem_sign_ext  = 1'b0;
        dec.is_branch_jal = 1'b0;

        case (op)
            rv_id_pkg::OPCODE_LUI: begin
                dec.rf_we     = 1'b1;
                dec.imm       = imm_u;
                dec.src_a_sel = rv_id_pkg::SRC_A_ZERO;
                dec.alu_op    = rv_id_pkg::ALU_PASS_B;
            end
            rv_id_pkg::OPCODE_AUIPC: begin
                dec.rf_we     = 1'b1;
                dec.imm       = imm_u;
                dec.src_a_sel = rv_id_pkg::SRC_A_PC;
            end
            rv_id_pkg::OPCODE_JAL: begin
                dec.rf_we         = 1'b1;
                dec.imm           = imm_j;
                dec.src_a_sel     = rv_id_pkg::SRC_A_PC;
                dec.is_branch_jal = 1'b1;
            end
            rv_id_pkg::OPCODE_JALR: begin
                dec.rf_we         = 1'b1;
                dec.rs1_used      = 1'b1;
                dec.is_branch_jal = 1'b1;
            end
            rv_id_pkg::OPCODE_BRANCH: begin
                // ALU forms the target, the branch unit compares rs1 and rs2
                dec.rs1_used      = 1'b1;
                dec.rs2_used      = 1'b1;
                dec.imm           = imm_b;
                dec.src_a_sel     = rv_id_pkg::SRC_A_PC;
                dec.is_branch_jal = 1'b1;
            end
            rv_id_pkg::OPCODE_LOAD: begin
                dec.rf_we        = 1'b1;
                dec.rs1_used     = 1'b1;
                dec.mem_rd       = 1'b1;
                dec.mem_size     = rv_id_pkg::mem_size_e'(ins.i.funct3[1:0]);
                dec.mem_sign_ext = ~ins.i.funct3[2];
            end
            rv_id_pkg::OPCODE_STORE: begin
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec.imm      = imm_s;
                dec.mem_wr   = 1'b1;
                dec.mem_size = rv_id_pkg::mem_size_e'(ins.s.funct3[1:0]);
            end
            rv_id_pkg::OPCODE_OP_IMM: begin
                dec.rf_we    = 1'b1;
                dec.rs1_used = 1'b1;
                // Bit 30 only selects SRAI, never a subtract
                dec.alu_op   = alu_from_funct(ins.i.funct3,
                                              ins.i.funct3 == 3'b101 && ins.r.funct7[5]);
            end
            rv_id_pkg::OPCODE_OP: begin
                dec.rf_we     = 1'b1;
                dec.rs1_used  = 1'b1;
                dec.rs2_used  = 1'b1;
                dec.src_b_sel = rv_id_pkg::SRC_B_REG;
                dec.alu_op    = alu_from_funct(ins.r.funct3, ins.r.funct7[5]);
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/operand_select.sv */
module operand_select (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    decode_if.operand                            dec,
    input  logic [rv_id_pkg::word_width-1:0]     pc_i,
    input  logic [rv_id_pkg::word_width-1:0]     rf_data_a_i,
    input  logic [rv_id_pkg::word_width-1:0]     rf_data_b_i,
    input  logic [rv_id_pkg::word_width-1:0]     ex_data_i,
    input  logic [rv_id_pkg::word_width-1:0]     mem_data_i,
    input  rv_id_pkg::bypass_sel_e               byp_a_i,
    input  rv_id_pkg::bypass_sel_e               byp_b_i,
    input  logic                                 load_use_i,
    input  logic                                 hazard_i,
    output logic [rv_id_pkg::reg_addr_width-1:0] idex_rd_o,
    output logic                                 idex_load_o,
    output rv_id_pkg::alu_op_e                   alu_op_o,
    output logic [rv_id_pkg::word_width-1:0]     alu_src_a_o,
    output logic [rv_id_pkg::word_width-1:0]     alu_src_b_o,
    output logic [rv_id_pkg::word_width-1:0]     br_src_a_o,
    output logic [rv_id_pkg::word_width-1:0]     br_src_b_o,
    output logic                                 rf_we_o,
    output logic [rv_id_pkg::reg_addr_width-1:0] rf_waddr_o,
    output logic                                 mem_rd_o,
    output logic                                 mem_wr_o,
    output rv_id_pkg::mem_size_e                 mem_size_o,
    output logic                                 mem_sign_ext_o,
    output logic [rv_id_pkg::word_width-1:0]     store_data_o,
    output logic                                 is_branch_jal_o
);

    logic [rv_id_pkg::word_width-1:0] fwd_a;
    logic [rv_id_pkg::word_width-1:0] fwd_b;
    logic [rv_id_pkg::word_width-1:0] alu_a;
    logic [rv_id_pkg::word_width-1:0] alu_b;
    logic [rv_id_pkg::word_width-1:0] br_a;
    logic [rv_id_pkg::word_width-1:0] nop_imm;
    logic                             is_jump;
    rv_id_pkg::instr_u                nop_word;

    function automatic logic [rv_id_pkg::word_width-1:0] forward(
        input rv_id_pkg::bypass_sel_e           sel,
        input logic [rv_id_pkg::word_width-1:0] rf_data,
        input logic [rv_id_pkg::word_width-1:0] ex_data,
        input logic [rv_id_pkg::word_width-1:0] mem_data
    );
        case (sel)
            rv_id_pkg::BY_EX:  return ex_data;
            rv_id_pkg::BY_MEM: return mem_data;
            default:           return rf_data;
        endcase
    endfunction

    assign fwd_a = forward(byp_a_i, rf_data_a_i, ex_data_i, mem_data_i);
    assign fwd_b = forward(byp_b_i, rf_data_b_i, ex_data_i, mem_data_i);

    always_comb begin
        case (dec.src_a_sel)
            rv_id_pkg::SRC_A_REG: alu_a = fwd_a;
            rv_id_pkg::SRC_A_PC:  alu_a = pc_i;
            default:              alu_a = '0;
        endcase
    end

    assign alu_b = (dec.src_b_sel == rv_id_pkg::SRC_B_IMM) ? dec.imm : fwd_b;

    // Jumps hand the link address to the branch unit
    assign is_jump = dec.opcode == rv_id_pkg::OPCODE_JAL ||
                     dec.opcode == rv_id_pkg::OPCODE_JALR;
    assign br_a    = is_jump ? pc_i + 32'd4 : fwd_a;

    assign nop_word = rv_id_pkg::nop_instr;
    assign nop_imm  = {{20{nop_word.i.imm[11]}}, nop_word.i.imm};

    assign idex_rd_o   = rf_waddr_o;
    assign idex_load_o = mem_rd_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_op_o        <= rv_id_pkg::ALU_ADD;
            alu_src_a_o     <= '0;
            alu_src_b_o     <= '0;
            br_src_a_o      <= '0;
            br_src_b_o      <= '0;
            rf_we_o         <= 1'b0;
            rf_waddr_o      <= '0;
            mem_rd_o        <= 1'b0;
            mem_wr_o        <= 1'b0;
            mem_size_o      <= rv_id_pkg::MEM_BYTE;
            mem_sign_ext_o  <= 1'b0;
            store_data_o    <= '0;
            is_branch_jal_o <= 1'b0;
        end else if (load_use_i) begin
            // Bubble, the held instruction is taken next time
            alu_op_o        <= rv_id_pkg::ALU_ADD;
            alu_src_a_o     <= '0;
            alu_src_b_o     <= nop_imm;
            br_src_a_o      <= '0;
            br_src_b_o      <= '0;
            rf_we_o         <= 1'b0;
            rf_waddr_o      <= nop_word.i.rd;
            mem_rd_o        <= 1'b0;
            mem_wr_o        <= 1'b0;
            mem_size_o      <= rv_id_pkg::MEM_WORD;
            mem_sign_ext_o  <= 1'b0;
            store_data_o    <= '0;
            is_branch_jal_o <= 1'b0;
        end else if (!hazard_i) begin
            alu_op_o        <= dec.alu_op;
            alu_src_a_o     <= alu_a;
            alu_src_b_o     <= alu_b;
            br_src_a_o      <= br_a;
            br_src_b_o      <= fwd_b;
            rf_we_o         <= dec.rf_we;
            rf_waddr_o      <= dec.rd;
            mem_rd_o        <= dec.mem_rd;
            mem_wr_o        <= dec.mem_wr;
            mem_size_o      <= dec.mem_size;
            mem_sign_ext_o  <= dec.mem_sign_ext;
            store_data_o    <= fwd_b;
            is_branch_jal_o <= dec.is_branch_jal;
        end
    end

endmodule

/* hw/rv_id_pkg.sv */
package rv_id_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;

    typedef enum logic [6:0] {
        OPCODE_NONE   = 7'b0000000,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;
    typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_sel_e;
    typedef enum logic [1:0] {BY_RF, BY_EX, BY_MEM} bypass_sel_e;
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]               imm;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                imm_hi;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [4:0]                imm_lo;
        logic [6:0]                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                      imm12;
        logic [5:0]                imm10_5;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [3:0]                imm4_1;
        logic                      imm11;
        logic [6:0]                opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]               imm;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                      imm20;
        logic [9:0]                imm10_1;
        logic                      imm11;
        logic [7:0]                imm19_12;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } j_fmt_t;

    // One instruction word, six format views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // ADDI x0, x0, 0
    localparam instr_u nop_instr = 32'h0000_0013;

endpackage

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module id_stage_tb \
    -f verilog.f -o sim_id_stage && ./obj_dir/sim_id_stage; } > sim.log 2>&1 \
    || echo "run ended with an error status" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log && exit 0 || exit 1

/* verilog.f */
hw/rv_id_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/bypass_controller.sv
hw/operand_select.sv
hw/id_stage_top.sv
bench/id_stage_properties.sv
bench/id_stage_tb.sv
